/* flist.f */
verilog/video_pkg.sv
verilog/h_timing.sv
verilog/v_timing.sv
verilog/scroll_regs.sv
verilog/scroll_calc.sv
verilog/video_timing_top.sv
verif/tb_video_timing.sv

/* run.sh */
#!/bin/sh
# Build the raster timing testbench with Verilator, run it, then scan the log
LOG=sim.log
rm -f "$LOG" build.log
verilator --binary --timing -j 0 --top-module tb_video_timing -f flist.f \
    -o tb_video_timing > build.log 2>&1 \
    && ./obj_dir/tb_video_timing > "$LOG" 2>&1 \
    || { cat build.log; echo "Build or simulation did not complete" >> "$LOG"; }
cat "$LOG"
if grep -q "TESTBENCH FAILED" "$LOG" || ! grep -q "TESTBENCH PASSED" "$LOG"
then
    echo "Simulation failed"
    exit 1
fi
exit 0

/* verif/scroll_cases.txt */
// scroll_x fx8 flip adj_en expected_fv, all hex, expected fv assumes line v = 0x20
00 0 0 0 020
00 0 1 0 0DF
00 0 0 1 1F8
00 0 1 1 0B7
10 0 0 0 030
FF 0 0 0 11F
FF 1 0 0 01F
FF 1 1 0 0DE
80 1 1 1 037
80 0 1 1 137
40 0 0 1 038
5A 0 0 0 07A
5A 1 0 0 17A
5A 1 1 0 039
5A 1 1 1 011
A5 0 0 1 09D
A5 1 0 1 19D
01 0 0 0 021
08 0 0 1 000
07 0 0 1 1FF
E0 1 0 0 000
E0 1 1 1 097
21 0 1 0 100
33 1 0 1 12B
C8 0 1 1 17F
7F 1 0 0 19F
00 1 1 1 1B7
F0 0 0 0 110

/* verif/tb_video_timing.sv */
// Testbench for the raster timing generator
// Clock, APB driver, case file reader, beam and scroll checks, watchdog
`timescale 1ns/100ps

module tb_video_timing;
    import video_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;               // After the rising edge
    localparam int LINE_CYCLES  = 384 * PIX_DIV;   // 384 pixels per line
    localparam int FRAME_CYCLES = 256 * LINE_CYCLES;
    localparam int WATCHDOG_NS  = 3 * FRAME_CYCLES * CLK_PERIOD;
    localparam int NUM_CASES    = 28;

    logic       clk;
    logic       rst;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    h_beam_t    h_beam;
    v_beam_t    v_beam;
    logic [7:0] x;
    logic [7:0] y;
    logic [8:0] fv;
    logic [8:0] case_mem [0:NUM_CASES*5-1];  // Five columns per case
    logic [8:0] status_seen;                 // {vblank, v} during APB setup
    logic       cases_bad;
    int         error_count;
    int         test_count;
    int         failed_tests;
    int         test_start_errors;

    video_timing_top UUT (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .h_beam  (h_beam),
        .v_beam  (v_beam),
        .x       (x),
        .y       (y),
        .fv      (fv)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Three frames, well past the longest wait for line 0x20
    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: simulation still running after three frame times");
        $display("TESTBENCH FAILED");
        $finish;
    end

    //******************************
    // Check helpers
    //******************************
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Error: %s expected 0x%0h got 0x%0h at %0t", name, exp, got, $time);
            error_count++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("Failure: %s at %0t", msg, $time);
        error_count++;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_start_errors)
            $display("Test %0d %s: ok", test_count, name);
        else
        begin
            failed_tests++;
            $display("Test %0d %s: %0d errors", test_count, name,
                     error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    //******************************
    // APB driver
    //******************************
    // Called at DRIVE_DELAY after an edge, returns at the same point
    task automatic apb_xfer(input logic wr, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
        int waits;
        apb_req.psel    = 1'b1;   // Setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        status_seen     = {v_beam.vblank, v_beam.v};
        next_cycle();
        apb_req.penable = 1'b1;   // Access phase
        waits = 0;
        while (!apb_rsp.pready && waits < 16)
        begin
            next_cycle();
            waits++;
        end
        if (!apb_rsp.pready)
            note_failure("pready never rose in the access phase");
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        next_cycle();             // Write lands on this edge
        apb_req = '0;
    endtask

    task automatic reg_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_value("pslverr", 32'(err), 32'd0);
    endtask

    task automatic reg_read_check(input logic [11:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 32'd0, rd, err);
        check_value("pslverr", 32'(err), 32'd0);
        check_value("prdata", rd, exp);
    endtask

    //******************************
    // Beam tests
    //******************************
    // One line from an hsync rise to the next
    task automatic horizontal_test;
        int   cycles;
        int   sync_hi;
        int   disp_lo;
        logic prev_sync;
        logic rose;
        rose   = 1'b0;
        cycles = 0;
        while (!rose && cycles < 2 * LINE_CYCLES)
        begin
            prev_sync = h_beam.hsync;
            next_cycle();
            cycles++;
            rose = h_beam.hsync && !prev_sync;
        end
        if (!rose)
            note_failure("hsync never rose within two line times");
        cycles  = 0;
        sync_hi = 1;                        // Rise cycle itself
        disp_lo = h_beam.hblank ? 0 : 1;
        rose    = 1'b0;
        while (!rose && cycles < 2 * LINE_CYCLES)
        begin
            prev_sync = h_beam.hsync;
            next_cycle();
            cycles++;
            rose = h_beam.hsync && !prev_sync;
            if (!rose && h_beam.hsync)
                sync_hi++;
            if (!rose && !h_beam.hblank)
                disp_lo++;
        end
        check_value("hsync period", cycles, LINE_CYCLES);
        check_value("hsync width", sync_hi, 32 * PIX_DIV);
        check_value("hblank low", disp_lo, 256 * PIX_DIV);
        end_test("horizontal timing");
    endtask

    // 256 line steps cover one whole frame from any start
    task automatic vertical_test;
        int         cycles;
        int         sync_lines;
        logic [7:0] prev_v;
        logic [7:0] exp_v;
        logic       exp_blank;
        logic       exp_sync;
        sync_lines = 0;
        for (int n = 0; n < 256; n++)
        begin
            prev_v = v_beam.v;
            exp_v  = prev_v + 8'd1;        // Wraps 0xFF to 0x00
            cycles = 0;
            while (v_beam.v == prev_v && cycles <= LINE_CYCLES)
            begin
                next_cycle();
                cycles++;
            end
            if (v_beam.v == prev_v)
                note_failure("v did not advance within one line time");
            else if (n > 0)
                check_value("line length", cycles, LINE_CYCLES);
            check_value("v_beam.v", 32'(v_beam.v), 32'(exp_v));
            exp_blank = (v_beam.v < V_DISP_START) || (v_beam.v > V_DISP_END);
            exp_sync  = (v_beam.v >= V_SYNC_START) && (v_beam.v <= V_SYNC_END);
            check_value("v_beam.vblank", 32'(v_beam.vblank), 32'(exp_blank));
            check_value("v_beam.vsync", 32'(v_beam.vsync), 32'(exp_sync));
            if (v_beam.vsync)
                sync_lines++;
        end
        check_value("vsync lines", sync_lines, 4);
        end_test("vertical timing");
    endtask

    //******************************
    // Register and scroll tests
    //******************************
    task automatic apb_test;
        logic [31:0] rd;
        logic        err;
        reg_write(REG_SCROLL, 32'h0000_00A5);
        reg_read_check(REG_SCROLL, 32'h0000_00A5);
        reg_write(REG_CTRL, 32'h0000_0005);
        reg_read_check(REG_CTRL, 32'h0000_0005);
        reg_write(REG_CTRL, 32'h0000_0002);
        reg_read_check(REG_CTRL, 32'h0000_0002);
        apb_xfer(1'b0, REG_STATUS, 32'd0, rd, err);
        check_value("pslverr", 32'(err), 32'd0);
        check_value("prdata", rd, 32'(status_seen));
        apb_xfer(1'b1, REG_STATUS, 32'h0000_01FF, rd, err);  // Read only
        check_value("pslverr", 32'(err), 32'd1);
        apb_xfer(1'b1, 12'h00C, 32'h0000_00FF, rd, err);     // Unmapped
        check_value("pslverr", 32'(err), 32'd1);
        apb_xfer(1'b0, 12'h00C, 32'd0, rd, err);
        check_value("pslverr", 32'(err), 32'd1);
        reg_read_check(REG_SCROLL, 32'h0000_00A5);           // Nothing moved
        reg_read_check(REG_CTRL, 32'h0000_0002);
        end_test("APB register access");
    endtask

    // x and y lag the beam by one clk
    task automatic flip_test(input logic flip, input string name);
        logic [7:0] prev_v;
        logic [8:0] prev_h;
        logic [7:0] mask;
        mask = {8{flip}};
        reg_write(REG_CTRL, 32'(flip) << CTRL_FLIP_BIT);
        next_cycle();
        for (int i = 0; i < 64; i++)
        begin
            prev_v = v_beam.v;
            prev_h = h_beam.h;
            next_cycle();
            check_value("x", 32'(x), 32'(prev_v ^ mask));
            check_value("y", 32'(y), 32'({prev_h[7:3] ^ mask[4:0], 3'b000}));
        end
        end_test(name);
    endtask

    task automatic scroll_test;
        logic [31:0] ctrl;
        logic [7:0]  prev_x;
        int          stable;
        int          cycles;
        for (int c = 0; c < NUM_CASES; c++)
        begin
            ctrl = (32'(case_mem[c*5+1][0]) << CTRL_FX8_BIT)
                   | (32'(case_mem[c*5+2][0]) << CTRL_FLIP_BIT)
                   | (32'(case_mem[c*5+3][0]) << CTRL_ADJ_BIT);
            reg_write(REG_SCROLL, 32'(case_mem[c*5]));
            reg_write(REG_CTRL, ctrl);
            stable = 0;
            cycles = 0;
            prev_x = x;
            // Line 0x20 with x unchanged for two clk
            while (stable < 2 && cycles < FRAME_CYCLES + LINE_CYCLES)
            begin
                next_cycle();
                cycles++;
                if (v_beam.v == 8'h20 && x == prev_x)
                    stable++;
                else
                    stable = 0;
                prev_x = x;
            end
            if (stable < 2)
                note_failure($sformatf("case %0d never settled on line 0x20", c));
            else if (x != (8'h20 ^ {8{case_mem[c*5+2][0]}}))
                note_failure($sformatf("case %0d sampled with x not from line 0x20", c));
            else
                check_value($sformatf("fv case %0d", c), 32'(fv), 32'(case_mem[c*5+4]));
        end
        end_test("scroll sum");
    endtask

    //******************************
    // Main sequence
    //******************************
    initial
    begin
        rst               = 1'b1;
        apb_req           = '0;
        status_seen       = '0;
        error_count       = 0;
        test_count        = 0;
        failed_tests      = 0;
        test_start_errors = 0;
        cases_bad         = 1'b0;
        foreach (case_mem[i])
            case_mem[i] = 9'h100 | 9'(i);  // Flags above 1 mark unloaded entries
        $readmemh("verif/scroll_cases.txt", case_mem);
        for (int c = 0; c < NUM_CASES; c++)
            if (case_mem[c*5+1] > 9'd1 || case_mem[c*5+2] > 9'd1 || case_mem[c*5+3] > 9'd1)
                cases_bad = 1'b1;
        if (cases_bad)
            note_failure("case file verif/scroll_cases.txt is missing or incomplete");
        repeat (8) @(posedge clk);
        #(DRIVE_DELAY);
        check_value("h_beam", 32'(h_beam), 32'({H_FIRST, 1'b1, 1'b0}));
        check_value("v_beam", 32'(v_beam), 32'({8'h00, 1'b1, 1'b0}));
        check_value("x", 32'(x), 32'd0);
        check_value("y", 32'(y), 32'd0);
        check_value("fv", 32'(fv), 32'd0);
        check_value("pready, pslverr", 32'({apb_rsp.pready, apb_rsp.pslverr}), 32'd0);
        check_value("prdata", apb_rsp.prdata, 32'd0);
        rst = 1'b0;
        reg_read_check(REG_SCROLL, 32'd0);
        reg_read_check(REG_CTRL, 32'd0);
        end_test("reset values");
        horizontal_test();
        vertical_test();
        apb_test();
        flip_test(1'b0, "flip clear");
        flip_test(1'b1, "flip set");
        scroll_test();
        $display("Tests run %0d, failed %0d, errors %0d", test_count, failed_tests,
                 error_count);
        if (error_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* verilog/video_timing_top.sv */
// Raster timing generator top level
// Beam counters, APB scroll registers and scroll adder
`timescale 1ns/100ps

module video_timing_top (
    input  logic                clk,
    input  logic                rst,
    input  video_pkg::apb_req_t apb_req,
    output video_pkg::apb_rsp_t apb_rsp,
    output video_pkg::h_beam_t  h_beam,
    output video_pkg::v_beam_t  v_beam,
    output logic [7:0]          x,
    output logic [7:0]          y,
    output logic [8:0]          fv
);
    import video_pkg::*;

    logic        line_end;  // Last pixel of each line
    scroll_cfg_t cfg;       // From the register block

    // Pixel clock and horizontal counter
    h_timing u_h_timing (
        .clk      (clk),
        .rst      (rst),
        .h_beam   (h_beam),
        .line_end (line_end)
    );

    // Line counter
    v_timing u_v_timing (
        .clk      (clk),
        .rst      (rst),
        .line_end (line_end),
        .v_beam   (v_beam)
    );

    // CPU registers
    scroll_regs u_scroll_regs (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .v_beam  (v_beam),
        .cfg     (cfg)
    );

    // Flip and scroll
    scroll_calc u_scroll_calc (
        .clk    (clk),
        .rst    (rst),
        .h_beam (h_beam),
        .v_beam (v_beam),
        .cfg    (cfg),
        .x      (x),
        .y      (y),
        .fv     (fv)
    );

endmodule

/* verilog/scroll_calc.sv */
// Beam coordinate flip and front layer scroll adder
// Registered x, y and scroll sum fv
`timescale 1ns/100ps

module scroll_calc (
    input  logic                   clk,
    input  logic                   rst,
    input  video_pkg::h_beam_t     h_beam,
    input  video_pkg::v_beam_t     v_beam,
    input  video_pkg::scroll_cfg_t cfg,
    output logic [7:0]             x,
    output logic [7:0]             y,
    output logic [8:0]             fv
);
    import video_pkg::*;

    logic [7:0] x_inv;   // Line, flipped when asked
    logic [4:0] y_inv;   // Tile column bits of h
    logic [8:0] adj;     // Flip offset or zero
    logic [8:0] fv_sum;

    always_comb
    begin
        x_inv  = v_beam.v ^ {8{cfg.flip}};
        y_inv  = h_beam.h[7:3] ^ {5{cfg.flip}};
        adj    = cfg.adj_en ? FLIP_ADJUST : 9'd0;
        // Nine bit sum, wraps mod 512
        fv_sum = {cfg.fx8, cfg.scroll_x} + {1'b0, x_inv} - adj;
    end

    //******************************
    // Output registers
    //******************************
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            x  <= 8'd0;
            y  <= 8'd0;
            fv <= 9'd0;
        end
        else
        begin
            x  <= x_inv;
            y  <= {y_inv, 3'b000};  // Pixel bits dropped
            fv <= fv_sum;
        end
    end

endmodule

/* verilog/scroll_regs.sv */
// APB slave register block
// Scroll and control registers, status readback, error response
`timescale 1ns/100ps

module scroll_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  video_pkg::apb_req_t    apb_req,
    output video_pkg::apb_rsp_t    apb_rsp,
    input  video_pkg::v_beam_t     v_beam,
    output video_pkg::scroll_cfg_t cfg
);
    import video_pkg::*;

    logic        setup_ph;    // psel, no penable
    logic        access_ph;   // psel and penable
    logic        hit_scroll;
    logic        hit_ctrl;
    logic        hit_status;
    logic        addr_err;    // Unmapped, or write to status
    logic        wr_en;
    logic [31:0] rd_data;
    scroll_cfg_t cfg_q;
    apb_rsp_t    rsp_q;

    //******************************
    // Address decode
    //******************************
    assign setup_ph   = apb_req.psel && !apb_req.penable;
    assign access_ph  = apb_req.psel && apb_req.penable;
    assign hit_scroll = (apb_req.paddr == REG_SCROLL);
    assign hit_ctrl   = (apb_req.paddr == REG_CTRL);
    assign hit_status = (apb_req.paddr == REG_STATUS);
    assign addr_err   = !(hit_scroll || hit_ctrl || hit_status)
                        || (hit_status && apb_req.pwrite);
    assign wr_en      = access_ph && apb_req.pwrite && !addr_err;

    // Register writes, at the end of the access phase
    always_ff @(posedge clk)
    begin
        if (rst)
            cfg_q <= '0;
        else if (wr_en)
        begin
            if (hit_scroll)
                cfg_q.scroll_x <= apb_req.pwdata[7:0];
            if (hit_ctrl)
            begin
                cfg_q.fx8    <= apb_req.pwdata[CTRL_FX8_BIT];
                cfg_q.flip   <= apb_req.pwdata[CTRL_FLIP_BIT];
                cfg_q.adj_en <= apb_req.pwdata[CTRL_ADJ_BIT];
            end
        end
    end

    //******************************
    // Read data and response
    //******************************
    always_comb
    begin
        rd_data = '0;
        if (hit_scroll)
            rd_data[7:0] = cfg_q.scroll_x;
        else if (hit_ctrl)
        begin
            rd_data[CTRL_FX8_BIT]  = cfg_q.fx8;
            rd_data[CTRL_FLIP_BIT] = cfg_q.flip;
            rd_data[CTRL_ADJ_BIT]  = cfg_q.adj_en;
        end
        else if (hit_status)
            rd_data[8:0] = {v_beam.vblank, v_beam.v};  // Live beam
    end

    // Response built in setup, presented for the whole access phase
    always_ff @(posedge clk)
    begin
        if (rst)
            rsp_q <= '0;
        else if (setup_ph)
        begin
            rsp_q.pready  <= 1'b1;    // Never waits
            rsp_q.pslverr <= addr_err;
            rsp_q.prdata  <= apb_req.pwrite ? 32'd0 : rd_data;
        end
        else
            rsp_q <= '0;              // Idle between transfers
    end

    assign apb_rsp = rsp_q;
    assign cfg     = cfg_q;

endmodule

/* verilog/v_timing.sv */
// Vertical beam timing
// Line counter stepped at line end, registered vblank and vsync
`timescale 1ns/100ps

module v_timing (
    input  logic               clk,
    input  logic               rst,
    input  logic               line_end,
    output video_pkg::v_beam_t v_beam
);
    import video_pkg::*;

    logic [7:0] v_next;       // Line after this one
    logic       vblank_next;
    logic       vsync_next;
    v_beam_t    beam_q;

    //******************************
    // Line counter
    //******************************
    always_comb
    begin
        if (beam_q.v == V_LAST)
            v_next = 8'd0;    // New frame
        else
            v_next = beam_q.v + 8'd1;

        // Windows looked up on the next line
        vblank_next = !((v_next >= V_DISP_START) && (v_next <= V_DISP_END));
        vsync_next  = (v_next >= V_SYNC_START) && (v_next <= V_SYNC_END);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            beam_q.v      <= 8'd0;
            beam_q.vblank <= 1'b1;    // Line 0 is above the display
            beam_q.vsync  <= 1'b0;
        end
        else if (line_end)
        begin
            beam_q.v      <= v_next;
            beam_q.vblank <= vblank_next;
            beam_q.vsync  <= vsync_next;
        end
    end

    assign v_beam = beam_q;

endmodule

/* verilog/h_timing.sv */
// Horizontal beam timing
// Pixel enable divider, pixel counter, registered hblank and hsync, line end pulse
`timescale 1ns/100ps

module h_timing (
    input  logic               clk,
    input  logic               rst,
    output video_pkg::h_beam_t h_beam,
    output logic               line_end
);
    import video_pkg::*;

    logic [PIX_CNT_W-1:0] div_cnt;  // clk cycles within the pixel
    logic                 pix_cen;  // One clk per pixel
    logic [8:0]           h_next;   // Count after this pixel
    logic                 hblank_next;
    logic                 hsync_next;
    h_beam_t              beam_q;

    //******************************
    // Pixel clock enable
    //******************************
    assign pix_cen = (div_cnt == PIX_CNT_W'(PIX_DIV - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
            div_cnt <= '0;
        else if (pix_cen)
            div_cnt <= '0;   // Restart divider
        else
            div_cnt <= div_cnt + PIX_CNT_W'(1);
    end

    //******************************
    // Horizontal counter
    //******************************
    always_comb
    begin
        // Reload at end of line
        h_next      = (beam_q.h == H_LAST) ? H_FIRST : beam_q.h + 9'd1;
        hblank_next = !((h_next >= H_DISP_START) && (h_next <= H_DISP_END));
        hsync_next  = (h_next >= H_SYNC_START) && (h_next <= H_SYNC_END);
    end

    // Flags decoded from the next count so they move with h
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            beam_q.h      <= H_FIRST;
            beam_q.hblank <= 1'b1;    // H_FIRST is off screen
            beam_q.hsync  <= 1'b0;
        end
        else if (pix_cen)
        begin
            beam_q.h      <= h_next;
            beam_q.hblank <= hblank_next;
            beam_q.hsync  <= hsync_next;
        end
    end

    // Last pixel of the line, single clk
    assign line_end = pix_cen && (beam_q.h == H_LAST);

    assign h_beam = beam_q;

endmodule

/* verilog/video_pkg.sv */
// Shared definitions for the raster timing generator
// Beam timing constants, APB register map, beam and config structs
package video_pkg;

    //******************************
    // Pixel clock enable
    //******************************
    localparam int PIX_DIV   = 4;                // clk cycles per pixel
    localparam int PIX_CNT_W = $clog2(PIX_DIV);  // Divider counter width

    //******************************
    // Horizontal raster
    //******************************
    // 384 pixel line, counter loads 0x080 after 0x1FF
    localparam logic [8:0] H_FIRST      = 9'h080;
    localparam logic [8:0] H_LAST       = 9'h1FF;
    localparam logic [8:0] H_DISP_START = 9'h0C0; // First visible pixel
    localparam logic [8:0] H_DISP_END   = 9'h1BF; // Last visible pixel
    localparam logic [8:0] H_SYNC_START = 9'h1D0; // 32 pixel wide sync
    localparam logic [8:0] H_SYNC_END   = 9'h1EF;

    //******************************
    // Vertical raster
    //******************************
    // 256 lines, natural 8-bit wrap
    localparam logic [7:0] V_LAST       = 8'hFF;
    localparam logic [7:0] V_DISP_START = 8'h10;  // 224 visible lines
    localparam logic [7:0] V_DISP_END   = 8'hEF;
    localparam logic [7:0] V_SYNC_START = 8'hF8;  // Four sync lines
    localparam logic [7:0] V_SYNC_END   = 8'hFB;

    // Front layer offset for the flipped screen, 40 pixels
    localparam logic [8:0] FLIP_ADJUST  = 9'd40;

    //******************************
    // APB register map
    //******************************
    localparam logic [11:0] REG_SCROLL = 12'h000; // Scroll x, bits 7..0
    localparam logic [11:0] REG_CTRL   = 12'h004; // Control bits below
    localparam logic [11:0] REG_STATUS = 12'h008; // Read only, v and vblank

    localparam int CTRL_FX8_BIT  = 0;  // Scroll bit 8
    localparam int CTRL_FLIP_BIT = 1;  // Screen flip
    localparam int CTRL_ADJ_BIT  = 2;  // Apply FLIP_ADJUST

    //******************************
    // Structs
    //******************************
    typedef struct packed {
        logic [8:0] h;      // Pixel count
        logic       hblank; // High outside visible pixels
        logic       hsync;  // Active high
    } h_beam_t;

    typedef struct packed {
        logic [7:0] v;      // Line count
        logic       vblank; // High outside visible lines
        logic       vsync;  // Active high
    } v_beam_t;

    typedef struct packed {
        logic [7:0] scroll_x; // Front layer scroll, low byte
        logic       fx8;      // Scroll bit 8
        logic       flip;     // Invert beam coordinates
        logic       adj_en;   // Subtract FLIP_ADJUST from the sum
    } scroll_cfg_t;

    // CPU side bus
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

endpackage
